// File: include/game_sdram_defines.svh
`ifndef GAME_SDRAM_DEFINES_SVH
`define GAME_SDRAM_DEFINES_SVH

// SDRAM geometry
`define SDRAM_AW    22          // Word address, 4M x 16
`define NUM_BANKS   4           // One slot per client
`define SDRAM_CL    3           // Read to first word, at least 2

// Client address widths
`define MAIN_AW     20          // 16-bit words
`define SND_AW      16          // Bytes
`define PCM_AW      18          // Bytes
`define GFX_AW      19          // 32-bit words

// Region bases in SDRAM words, all even so a region starts on a line
`define MAIN_OFFSET 22'h00_0000
`define GFX_OFFSET  22'h10_0000 // 2M words of graphics
`define PCM_OFFSET  22'h30_0000
`define SND_OFFSET  22'h32_0000

// Client to slot numbering
`define MAIN_SLOT   0
`define SND_SLOT    1
`define PCM_SLOT    2
`define GFX_SLOT    3

`endif

// File: hdl/game_sdram_pkg.sv
`include "game_sdram_defines.svh"

package game_sdram_pkg;

// Full SDRAM word address
typedef logic [`SDRAM_AW-1:0] sdram_addr_t;

// Two words per line, so the word LSB is dropped
typedef logic [`SDRAM_AW-2:0] line_addr_t;

typedef logic [15:0] sdram_word_t;
typedef logic [31:0] line_t;    // Even word sits in [15:0]

typedef enum logic [1:0] {
    SLOT_IDLE,
    SLOT_WAIT_ACK,      // bank_rd up, waiting for the arbiter
    SLOT_WAIT_DATA
} slot_state_t;

typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_LATENCY,        // Counting CAS latency
    SEQ_FIRST,          // Even word on the bus
    SEQ_SECOND          // Odd word on the bus
} seq_state_t;

endpackage

// File: hdl/client_mapper.sv
`timescale 1ns/10ps
`include "game_sdram_defines.svh"

module client_mapper (
    input  logic                         clk,
    input  logic                         rst,
    // Game clients
    input  logic                         main_cs,
    input  logic [`MAIN_AW-1:0]          main_addr,
    output logic                         main_ok,
    output game_sdram_pkg::sdram_word_t  main_data,
    input  logic                         snd_cs,
    input  logic [`SND_AW-1:0]           snd_addr,
    output logic                         snd_ok,
    output logic [7:0]                   snd_data,
    input  logic                         pcm_cs,
    input  logic [`PCM_AW-1:0]           pcm_addr,
    output logic                         pcm_ok,
    output logic [7:0]                   pcm_data,
    input  logic                         gfx_cs,
    input  logic [`GFX_AW-1:0]           gfx_addr,
    output logic                         gfx_ok,
    output game_sdram_pkg::line_t        gfx_data,
    // Bank slots
    output logic [`NUM_BANKS-1:0]        slot_cs,
    output game_sdram_pkg::line_addr_t   slot_addr [`NUM_BANKS],
    input  logic [`NUM_BANKS-1:0]        slot_ok,
    input  game_sdram_pkg::line_t        slot_data [`NUM_BANKS]
);

// One extra bit on top of the line address catches overflow
game_sdram_pkg::sdram_addr_t line_full [`NUM_BANKS];
logic [1:0] snd_lane;
logic [1:0] pcm_lane;

// Byte 0 of a word is the low byte
function automatic logic [7:0] pick_byte(input game_sdram_pkg::line_t line,
                                         input logic [1:0] lane);
    game_sdram_pkg::sdram_word_t word;
    word = lane[1] ? line[31:16] : line[15:0];
    return lane[0] ? word[15:8] : word[7:0];
endfunction

assign slot_cs[`MAIN_SLOT] = main_cs;
assign slot_cs[`SND_SLOT]  = snd_cs;
assign slot_cs[`PCM_SLOT]  = pcm_cs;
assign slot_cs[`GFX_SLOT]  = gfx_cs;

// Offsets are word addresses, halved to get line units
assign line_full[`MAIN_SLOT] = game_sdram_pkg::sdram_addr_t'(main_addr[`MAIN_AW-1:1])
                             + (`MAIN_OFFSET >> 1);
assign line_full[`SND_SLOT]  = game_sdram_pkg::sdram_addr_t'(snd_addr[`SND_AW-1:2])
                             + (`SND_OFFSET >> 1);
assign line_full[`PCM_SLOT]  = game_sdram_pkg::sdram_addr_t'(pcm_addr[`PCM_AW-1:2])
                             + (`PCM_OFFSET >> 1);
assign line_full[`GFX_SLOT]  = game_sdram_pkg::sdram_addr_t'(gfx_addr)
                             + (`GFX_OFFSET >> 1); // Already one line per address

for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_line
    assign slot_addr[i] = line_full[i][`SDRAM_AW-2:0];

    a_in_range: assert property (@(posedge clk) disable iff (rst)
        slot_cs[i] |-> !line_full[i][`SDRAM_AW-1]);
end

// Lanes track the address and freeze while ok is shown
always_ff @(posedge clk) begin
    if (rst) begin
        snd_lane <= 2'd0;
        pcm_lane <= 2'd0;
    end else begin
        if (!slot_ok[`SND_SLOT]) snd_lane <= snd_addr[1:0];
        if (!slot_ok[`PCM_SLOT]) pcm_lane <= pcm_addr[1:0];
    end
end

assign main_ok   = slot_ok[`MAIN_SLOT];
assign main_data = main_addr[0] ? slot_data[`MAIN_SLOT][31:16] : slot_data[`MAIN_SLOT][15:0];
assign snd_ok    = slot_ok[`SND_SLOT];
assign snd_data  = pick_byte(slot_data[`SND_SLOT], snd_lane);
assign pcm_ok    = slot_ok[`PCM_SLOT];
assign pcm_data  = pick_byte(slot_data[`PCM_SLOT], pcm_lane);
assign gfx_ok    = slot_ok[`GFX_SLOT];
assign gfx_data  = slot_data[`GFX_SLOT];

endmodule

// File: hdl/bank_slot.sv
`timescale 1ns/10ps
`include "game_sdram_defines.svh"

module bank_slot (
    input  logic                         clk,
    input  logic                         rst,
    // Client side, already mapped to a line
    input  logic                         slot_cs,
    input  game_sdram_pkg::line_addr_t   slot_addr,
    output logic                         slot_ok,
    output game_sdram_pkg::line_t        slot_data,
    // Sequencer side
    output logic                         bank_rd,
    output game_sdram_pkg::sdram_addr_t  bank_addr,
    input  logic                         bank_ack,
    input  logic                         bank_dst,
    input  logic                         bank_rdy,
    input  game_sdram_pkg::sdram_word_t  data_read
);

game_sdram_pkg::slot_state_t state;
game_sdram_pkg::line_addr_t  tag;
game_sdram_pkg::line_addr_t  fill_line;
logic valid;
logic hit;
logic start_fetch;
logic fill_match;

assign fill_line   = bank_addr[`SDRAM_AW-1:1];
assign hit         = valid && (tag == slot_addr);
assign start_fetch = (state == game_sdram_pkg::SLOT_IDLE) && slot_cs && !hit;
// Client still wants the line being filled
assign fill_match  = slot_cs && (fill_line == slot_addr);

always_ff @(posedge clk) begin
    if (rst) begin
        state   <= game_sdram_pkg::SLOT_IDLE;
        valid   <= 1'b0;
        slot_ok <= 1'b0;
        bank_rd <= 1'b0;
    end else begin
        case (state)
            game_sdram_pkg::SLOT_IDLE: begin
                // ok drops for a cycle after each hit, so a new address gets
                // its own compare before ok returns
                slot_ok <= slot_cs && hit && !slot_ok;
                if (start_fetch) begin
                    bank_rd <= 1'b1;
                    state   <= game_sdram_pkg::SLOT_WAIT_ACK;
                end
            end
            game_sdram_pkg::SLOT_WAIT_ACK: begin
                if (bank_ack) begin
                    bank_rd <= 1'b0;
                    state   <= game_sdram_pkg::SLOT_WAIT_DATA;
                end
            end
            game_sdram_pkg::SLOT_WAIT_DATA: begin
                if (bank_rdy) begin
                    valid   <= 1'b1;
                    slot_ok <= fill_match;
                    state   <= game_sdram_pkg::SLOT_IDLE;
                end
            end
            default: state <= game_sdram_pkg::SLOT_IDLE;
        endcase
    end
end

// Line contents and the fetch address
always_ff @(posedge clk) begin
    if (start_fetch) bank_addr <= {slot_addr, 1'b0}; // Lines start on even words
    if (bank_dst) slot_data[15:0] <= data_read;
    if (bank_rdy) begin
        slot_data[31:16] <= data_read;
        tag              <= fill_line;
    end
end

// The arbiter may keep a slot waiting for several line fetches
a_rd_held: assert property (@(posedge clk) disable iff (rst)
    bank_rd && !bank_ack |=> bank_rd);

// Data pulses only for a slot with a granted fetch
a_dst_state: assert property (@(posedge clk) disable iff (rst)
    bank_dst |-> state == game_sdram_pkg::SLOT_WAIT_DATA);

endmodule

// File: hdl/bank_sequencer.sv
`timescale 1ns/10ps
`include "game_sdram_defines.svh"

module bank_sequencer (
    input  logic                         clk,
    input  logic                         rst,
    // Bank slots
    input  logic [`NUM_BANKS-1:0]        bank_rd,
    input  game_sdram_pkg::sdram_addr_t  bank_addr [`NUM_BANKS],
    output logic [`NUM_BANKS-1:0]        bank_ack,
    output logic [`NUM_BANKS-1:0]        bank_dst,
    output logic [`NUM_BANKS-1:0]        bank_rdy,
    output game_sdram_pkg::sdram_word_t  data_read,
    // SDRAM read port
    output logic                         sdram_rd,
    output game_sdram_pkg::sdram_addr_t  sdram_addr,
    input  game_sdram_pkg::sdram_word_t  sdram_data
);

localparam int IDX_W = $clog2(`NUM_BANKS);
localparam int CNT_W = $clog2(`SDRAM_CL) + 1;

game_sdram_pkg::seq_state_t state;
logic [`NUM_BANKS-1:0] grant;
logic [`NUM_BANKS-1:0] owner;       // Bank whose line is in flight
logic [IDX_W-1:0]      grant_idx;
logic [IDX_W-1:0]      last_idx;    // Last winner
logic [CNT_W-1:0]      lat_cnt;
logic                  take;

// Round robin, the bank right after the last winner comes first
always_comb begin
    int unsigned k;
    grant     = '0;
    grant_idx = last_idx;
    for (int i = `NUM_BANKS; i >= 1; i--) begin
        k = (last_idx + i) % `NUM_BANKS;
        if (bank_rd[k]) begin
            grant     = '0;
            grant[k]  = 1'b1;
            grant_idx = IDX_W'(k);
        end
    end
end

assign take = (state == game_sdram_pkg::SEQ_IDLE) && |bank_rd;

always_ff @(posedge clk) begin
    if (rst) begin
        state    <= game_sdram_pkg::SEQ_IDLE;
        owner    <= '0;
        last_idx <= IDX_W'(`NUM_BANKS - 1); // Bank 0 wins first
        lat_cnt  <= '0;
    end else begin
        case (state)
            game_sdram_pkg::SEQ_IDLE: begin
                if (take) begin
                    owner    <= grant;
                    last_idx <= grant_idx;
                    lat_cnt  <= CNT_W'(`SDRAM_CL - 1);
                    state    <= game_sdram_pkg::SEQ_LATENCY;
                end
            end
            game_sdram_pkg::SEQ_LATENCY: begin
                lat_cnt <= lat_cnt - 1'b1;
                if (lat_cnt == CNT_W'(1)) state <= game_sdram_pkg::SEQ_FIRST;
            end
            game_sdram_pkg::SEQ_FIRST: state <= game_sdram_pkg::SEQ_SECOND;
            game_sdram_pkg::SEQ_SECOND: begin
                owner <= '0;
                state <= game_sdram_pkg::SEQ_IDLE; // Free for a grant next cycle
            end
            default: state <= game_sdram_pkg::SEQ_IDLE;
        endcase
    end
end

assign sdram_rd   = take;
assign sdram_addr = bank_addr[grant_idx];
assign bank_ack   = take ? grant : '0;   // Same cycle as sdram_rd
assign bank_dst   = (state == game_sdram_pkg::SEQ_FIRST)  ? owner : '0;
assign bank_rdy   = (state == game_sdram_pkg::SEQ_SECOND) ? owner : '0;
assign data_read  = sdram_data;          // Shared by all slots, dst/rdy pick the taker

a_one_ack: assert property (@(posedge clk) disable iff (rst)
    $onehot0(bank_ack));

// Exactly one bank owns the bus from ack to rdy
a_owner_onehot: assert property (@(posedge clk) disable iff (rst)
    state != game_sdram_pkg::SEQ_IDLE |-> $onehot(owner));

endmodule

// File: hdl/game_sdram.sv
`timescale 1ns/10ps
`include "game_sdram_defines.svh"

module game_sdram (
    input  logic                         clk,
    input  logic                         rst,
    // Main CPU ROM
    input  logic                         main_cs,
    input  logic [`MAIN_AW-1:0]          main_addr,
    output logic                         main_ok,
    output game_sdram_pkg::sdram_word_t  main_data,
    // Sound CPU ROM
    input  logic                         snd_cs,
    input  logic [`SND_AW-1:0]           snd_addr,
    output logic                         snd_ok,
    output logic [7:0]                   snd_data,
    // PCM samples
    input  logic                         pcm_cs,
    input  logic [`PCM_AW-1:0]           pcm_addr,
    output logic                         pcm_ok,
    output logic [7:0]                   pcm_data,
    // Graphics ROM
    input  logic                         gfx_cs,
    input  logic [`GFX_AW-1:0]           gfx_addr,
    output logic                         gfx_ok,
    output game_sdram_pkg::line_t        gfx_data,
    // SDRAM read port
    output logic                         sdram_rd,
    output game_sdram_pkg::sdram_addr_t  sdram_addr,
    input  game_sdram_pkg::sdram_word_t  sdram_data
);

logic [`NUM_BANKS-1:0] slot_cs;
logic [`NUM_BANKS-1:0] slot_ok;
logic [`NUM_BANKS-1:0] bank_rd;
logic [`NUM_BANKS-1:0] bank_ack;
logic [`NUM_BANKS-1:0] bank_dst;
logic [`NUM_BANKS-1:0] bank_rdy;
game_sdram_pkg::line_addr_t  slot_addr [`NUM_BANKS];
game_sdram_pkg::line_t       slot_data [`NUM_BANKS];
game_sdram_pkg::sdram_addr_t bank_addr [`NUM_BANKS];
game_sdram_pkg::sdram_word_t data_read;

client_mapper u_mapper (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .main_cs   ( main_cs   ),
    .main_addr ( main_addr ),
    .main_ok   ( main_ok   ),
    .main_data ( main_data ),
    .snd_cs    ( snd_cs    ),
    .snd_addr  ( snd_addr  ),
    .snd_ok    ( snd_ok    ),
    .snd_data  ( snd_data  ),
    .pcm_cs    ( pcm_cs    ),
    .pcm_addr  ( pcm_addr  ),
    .pcm_ok    ( pcm_ok    ),
    .pcm_data  ( pcm_data  ),
    .gfx_cs    ( gfx_cs    ),
    .gfx_addr  ( gfx_addr  ),
    .gfx_ok    ( gfx_ok    ),
    .gfx_data  ( gfx_data  ),
    .slot_cs   ( slot_cs   ),
    .slot_addr ( slot_addr ),
    .slot_ok   ( slot_ok   ),
    .slot_data ( slot_data )
);

// One cached line per client
for (genvar i = 0; i < `NUM_BANKS; i++) begin : u_slot
    bank_slot u_cache (
        .clk       ( clk          ),
        .rst       ( rst          ),
        .slot_cs   ( slot_cs[i]   ),
        .slot_addr ( slot_addr[i] ),
        .slot_ok   ( slot_ok[i]   ),
        .slot_data ( slot_data[i] ),
        .bank_rd   ( bank_rd[i]   ),
        .bank_addr ( bank_addr[i] ),
        .bank_ack  ( bank_ack[i]  ),
        .bank_dst  ( bank_dst[i]  ),
        .bank_rdy  ( bank_rdy[i]  ),
        .data_read ( data_read    )
    );
end

bank_sequencer u_seq (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .bank_rd    ( bank_rd    ),
    .bank_addr  ( bank_addr  ),
    .bank_ack   ( bank_ack   ),
    .bank_dst   ( bank_dst   ),
    .bank_rdy   ( bank_rdy   ),
    .data_read  ( data_read  ),
    .sdram_rd   ( sdram_rd   ),
    .sdram_addr ( sdram_addr ),
    .sdram_data ( sdram_data )
);

endmodule

// File: verification/sdram_checker.sv
`timescale 1ns/10ps
`include "game_sdram_defines.svh"

module sdram_checker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        main_cs,
    input  logic [`MAIN_AW-1:0]         main_addr,
    input  logic                        main_ok,
    input  logic [15:0]                 main_data,
    input  logic                        snd_cs,
    input  logic [`SND_AW-1:0]          snd_addr,
    input  logic                        snd_ok,
    input  logic [7:0]                  snd_data,
    input  logic                        pcm_cs,
    input  logic [`PCM_AW-1:0]          pcm_addr,
    input  logic                        pcm_ok,
    input  logic [7:0]                  pcm_data,
    input  logic                        gfx_cs,
    input  logic [`GFX_AW-1:0]          gfx_addr,
    input  logic                        gfx_ok,
    input  logic [31:0]                 gfx_data,
    input  logic                        sdram_rd,
    input  logic [`SDRAM_AW-1:0]        sdram_addr,
    input  logic [2:0]                  test_id,
    input  logic                        test_done,
    input  logic                        finished,
    output logic [15:0]                 error_count
);

localparam int MISS_CYCLES = `SDRAM_CL + 3;

logic [`NUM_BANKS-1:0] cs_v;
logic [`NUM_BANKS-1:0] ok_v;
logic [31:0] addr_v [`NUM_BANKS];
logic [31:0] data_v [`NUM_BANKS];
logic [31:0] base [`NUM_BANKS];         // Even SDRAM word of the requested line
logic [31:0] last_base [`NUM_BANKS];    // Line the client fetched last
logic        have_line [`NUM_BANKS];
logic        busy [`NUM_BANKS];
logic        hit [`NUM_BANKS];
logic        crowded [`NUM_BANKS];      // Another client was active meanwhile
int          lat [`NUM_BANKS];
int          own_rd [`NUM_BANKS];
int          other_rd [`NUM_BANKS];
logic        seen_cs;
logic        closed;
int          test_reqs;
int          test_errs;
int          total_reqs;
int          num_tests;

assign cs_v = {gfx_cs, pcm_cs, snd_cs, main_cs};
assign ok_v = {gfx_ok, pcm_ok, snd_ok, main_ok};
assign addr_v[0] = 32'(main_addr);
assign addr_v[1] = 32'(snd_addr);
assign addr_v[2] = 32'(pcm_addr);
assign addr_v[3] = 32'(gfx_addr);
assign data_v[0] = 32'(main_data);
assign data_v[1] = 32'(snd_data);
assign data_v[2] = 32'(pcm_data);
assign data_v[3] = gfx_data;

// Same content as the memory model in the testbench
function automatic logic [15:0] pattern(input logic [31:0] w);
    return {w[7:0], ~w[15:8] ^ {2'b00, w[`SDRAM_AW-1:16]}};
endfunction

// SDRAM word that holds the requested data
function automatic logic [31:0] word_of(input int c, input logic [31:0] a);
    case (c)
        0: return `MAIN_OFFSET + a;
        1: return `SND_OFFSET + (a >> 1);
        2: return `PCM_OFFSET + (a >> 1);
        default: return `GFX_OFFSET + (a << 1);
    endcase
endfunction

function automatic logic [31:0] expected_data(input int c, input logic [31:0] a);
    logic [31:0] w;
    logic [15:0] d;
    w = word_of(c, a);
    d = pattern(w);
    case (c)
        0: return 32'(d);
        1, 2: return a[0] ? 32'(d[15:8]) : 32'(d[7:0]);
        default: return {pattern(w + 1), d};
    endcase
endfunction

function automatic string test_name(input logic [2:0] t);
    case (t)
        0: return "reset_idle";
        1: return "random_single";
        2: return "repeat_hit";
        3: return "contention";
        4: return "solo_miss";
        default: return "unknown";
    endcase
endfunction

function automatic string client_name(input int c);
    case (c)
        0: return "main";
        1: return "snd";
        2: return "pcm";
        default: return "gfx";
    endcase
endfunction

task automatic fail_value(input string what, input int c,
                          input logic [31:0] exp, input logic [31:0] act);
    $display("CHECK FAILED %s: %s %s expected %0h actual %0h",
             test_name(test_id), client_name(c), what, exp, act);
    test_errs++;
    error_count++;
endtask

task automatic fail_plain(input string msg);
    $display("ERROR in %s: %s", test_name(test_id), msg);
    test_errs++;
    error_count++;
endtask

task automatic finish_request(input int c);
    logic [31:0] exp;
    exp = expected_data(c, addr_v[c]);
    test_reqs++;
    if (data_v[c] !== exp) fail_value("data", c, exp, data_v[c]);
    if (hit[c]) begin
        if (lat[c] != 1) fail_value("hit latency", c, 1, lat[c]);
        if (own_rd[c] != 0) fail_value("hit sdram_rd count", c, 0, own_rd[c]);
    end else begin
        if (own_rd[c] != 1) fail_value("miss sdram_rd count", c, 1, own_rd[c]);
        if (other_rd[c] > `NUM_BANKS - 1)
            fail_value("fetches ahead, at most", c, `NUM_BANKS - 1, other_rd[c]);
        if (!crowded[c] && lat[c] != MISS_CYCLES)
            fail_value("miss latency", c, MISS_CYCLES, lat[c]);
    end
    if (!crowded[c] && other_rd[c] != 0) fail_value("foreign sdram_rd", c, 0, other_rd[c]);
    last_base[c] = base[c];
    have_line[c] = 1'b1;
    busy[c]      = 1'b0;
endtask

always @(posedge clk) begin
    if (rst) begin
        for (int c = 0; c < `NUM_BANKS; c++) begin
            busy[c]      = 1'b0;
            have_line[c] = 1'b0;
        end
        seen_cs     = 1'b0;
        closed      = 1'b0;
        test_reqs   = 0;
        test_errs   = 0;
        total_reqs  = 0;
        num_tests   = 0;
        error_count = '0;
    end else begin
        if (!seen_cs && (|ok_v || sdram_rd))
            fail_plain("ok or sdram_rd went high before the first request");
        if (|cs_v) seen_cs = 1'b1;
        for (int c = 0; c < `NUM_BANKS; c++) begin
            if (busy[c]) begin
                lat[c]++;
                if (|(cs_v & ~(4'd1 << c))) crowded[c] = 1'b1;
                if (sdram_rd && sdram_addr == base[c][`SDRAM_AW-1:0]) own_rd[c]++;
                else if (sdram_rd && own_rd[c] == 0) other_rd[c]++;
                if (ok_v[c]) finish_request(c);
            end else if (ok_v[c]) begin
                fail_plain({client_name(c), " ok is high with no request pending"});
            end else if (cs_v[c]) begin
                busy[c]     = 1'b1;
                lat[c]      = 0;
                own_rd[c]   = 0;
                other_rd[c] = 0;
                base[c]     = word_of(c, addr_v[c]) & ~32'd1;
                hit[c]      = have_line[c] && (last_base[c] == base[c]);
                crowded[c]  = |(cs_v & ~(4'd1 << c));
            end
        end
        if (test_done) begin
            $display("test %0d %s: %0d requests, %0d errors",
                     test_id, test_name(test_id), test_reqs, test_errs);
            num_tests++;
            total_reqs += test_reqs;
            test_reqs = 0;
            test_errs = 0;
        end
        if (finished && !closed) begin
            $display("%0d tests, %0d requests, %0d errors", num_tests, total_reqs, error_count);
            closed = 1'b1;
        end
    end
end

endmodule

// File: verification/tb_game_sdram.sv
`timescale 1ns/10ps
`include "game_sdram_defines.svh"

module tb_game_sdram;

localparam int RAND_PER_CLIENT = 6;
localparam int HIT_STEPS       = 4;
localparam int CONT_ROUNDS     = 4;
localparam int SOLO_ROUNDS     = 2;
localparam int NUM_REQ     = 4 * (RAND_PER_CLIENT + HIT_STEPS + CONT_ROUNDS + SOLO_ROUNDS);
localparam int REQ_CYCLES  = 4 * (`SDRAM_CL + 3) + 4; // Behind three other fetches
localparam int WATCHDOG_NS = NUM_REQ * REQ_CYCLES * 8 + 2000;

logic clk;
logic rst;
logic main_cs;
logic [`MAIN_AW-1:0] main_addr;
logic main_ok;
game_sdram_pkg::sdram_word_t main_data;
logic snd_cs;
logic [`SND_AW-1:0] snd_addr;
logic snd_ok;
logic [7:0] snd_data;
logic pcm_cs;
logic [`PCM_AW-1:0] pcm_addr;
logic pcm_ok;
logic [7:0] pcm_data;
logic gfx_cs;
logic [`GFX_AW-1:0] gfx_addr;
logic gfx_ok;
game_sdram_pkg::line_t gfx_data;
logic sdram_rd;
game_sdram_pkg::sdram_addr_t sdram_addr;
game_sdram_pkg::sdram_word_t sdram_data;
logic [2:0] test_id;
logic test_done;
logic finished;
logic [15:0] error_count;
logic [`SDRAM_CL-1:0] rd_pipe;                      // Reads in flight, one bit per cycle
game_sdram_pkg::sdram_addr_t addr_pipe [`SDRAM_CL];
logic [31:0] rng;
logic [31:0] last_addr [4];
logic [31:0] cont_addr [4][CONT_ROUNDS];            // Back-to-back requests per client

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Low address byte on top, next byte inverted below with the region bits folded in
function automatic game_sdram_pkg::sdram_word_t mem_word(input game_sdram_pkg::sdram_addr_t a);
    return {a[7:0], ~a[15:8] ^ {2'b00, a[`SDRAM_AW-1:16]}};
endfunction

function automatic logic ok_of(input int c);
    case (c)
        0: return main_ok;
        1: return snd_ok;
        2: return pcm_ok;
        default: return gfx_ok;
    endcase
endfunction

task automatic drive(input int c, input logic cs, input logic [31:0] a);
    case (c)
        0: begin main_cs <= cs; main_addr <= a[`MAIN_AW-1:0]; end
        1: begin snd_cs <= cs; snd_addr <= a[`SND_AW-1:0]; end
        2: begin pcm_cs <= cs; pcm_addr <= a[`PCM_AW-1:0]; end
        default: begin gfx_cs <= cs; gfx_addr <= a[`GFX_AW-1:0]; end
    endcase
endtask

// Hold cs and addr until ok, then release
task automatic request(input int c, input logic [31:0] a);
    @(posedge clk);
    drive(c, 1'b1, a);
    last_addr[c] = a;
    do @(posedge clk); while (!ok_of(c));
    drive(c, 1'b0, a);
endtask

// One client asking again as soon as each request is done
task automatic request_burst(input int c);
    for (int r = 0; r < CONT_ROUNDS; r++) request(c, cont_addr[c][r]);
endtask

task automatic end_test();
    @(posedge clk);
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
    test_id   <= test_id + 1'b1;
endtask

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

// SDRAM model, even word CL cycles after the read and the odd word right behind it
always @(posedge clk) begin
    if (rst) begin
        rd_pipe    <= '0;
        sdram_data <= '0;
    end else begin
        rd_pipe      <= {rd_pipe[`SDRAM_CL-2:0], sdram_rd};
        addr_pipe[0] <= sdram_addr;
        for (int i = 1; i < `SDRAM_CL; i++) addr_pipe[i] <= addr_pipe[i-1];
        if (rd_pipe[`SDRAM_CL-2]) sdram_data <= mem_word(addr_pipe[`SDRAM_CL-2]);
        else if (rd_pipe[`SDRAM_CL-1]) sdram_data <= mem_word(addr_pipe[`SDRAM_CL-1] + 1'b1);
        else sdram_data <= 'x; // Bus idle
    end
end

game_sdram i_dut (
    .clk(clk), .rst(rst),
    .main_cs(main_cs), .main_addr(main_addr), .main_ok(main_ok), .main_data(main_data),
    .snd_cs(snd_cs), .snd_addr(snd_addr), .snd_ok(snd_ok), .snd_data(snd_data),
    .pcm_cs(pcm_cs), .pcm_addr(pcm_addr), .pcm_ok(pcm_ok), .pcm_data(pcm_data),
    .gfx_cs(gfx_cs), .gfx_addr(gfx_addr), .gfx_ok(gfx_ok), .gfx_data(gfx_data),
    .sdram_rd(sdram_rd), .sdram_addr(sdram_addr), .sdram_data(sdram_data)
);

sdram_checker u_checker (
    .clk(clk), .rst(rst),
    .main_cs(main_cs), .main_addr(main_addr), .main_ok(main_ok), .main_data(main_data),
    .snd_cs(snd_cs), .snd_addr(snd_addr), .snd_ok(snd_ok), .snd_data(snd_data),
    .pcm_cs(pcm_cs), .pcm_addr(pcm_addr), .pcm_ok(pcm_ok), .pcm_data(pcm_data),
    .gfx_cs(gfx_cs), .gfx_addr(gfx_addr), .gfx_ok(gfx_ok), .gfx_data(gfx_data),
    .sdram_rd(sdram_rd), .sdram_addr(sdram_addr),
    .test_id(test_id), .test_done(test_done), .finished(finished),
    .error_count(error_count)
);

initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, a request never got its ok");
    $display("Simulation FAILED");
    $finish;
end

initial begin
    logic [31:0] a;
    rst = 1'b1;
    drive(0, 1'b0, 32'd0);
    drive(1, 1'b0, 32'd0);
    drive(2, 1'b0, 32'd0);
    drive(3, 1'b0, 32'd0);
    sdram_data = '0;
    test_id    = '0;
    test_done  = 1'b0;
    finished   = 1'b0;
    rng        = 32'h4d3c;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    repeat (12) @(posedge clk); // Idle after reset
    end_test();
    for (int c = 0; c < 4; c++) begin
        for (int n = 0; n < RAND_PER_CLIENT; n++) begin
            rng = xorshift(rng);
            request(c, rng);
        end
    end
    end_test();
    for (int c = 0; c < 4; c++) begin
        rng = xorshift(rng);
        a = rng;
        request(c, a);
        request(c, a);          // Same line again
        request(c, a ^ 32'h1);  // Other lane, a new line only for gfx
        request(c, a ^ 32'h40);
    end
    end_test();
    for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < CONT_ROUNDS; r++) begin
            rng = xorshift(rng);
            cont_addr[c][r] = rng;
        end
    end
    fork
        request_burst(0);
        request_burst(1);
        request_burst(2);
        request_burst(3);
    join
    end_test();
    for (int r = 0; r < SOLO_ROUNDS; r++) begin
        for (int c = 0; c < 4; c++) request(c, last_addr[c] ^ 32'h100); // Always a new line
    end
    end_test();
    @(posedge clk);
    finished <= 1'b1;
    repeat (2) @(posedge clk);
    if (error_count == 0)
        $display("Simulation PASSED");
    else
        $display("Simulation FAILED");
    $finish;
end

endmodule

// File: src.f
+incdir+include
hdl/game_sdram_pkg.sv
hdl/client_mapper.sv
hdl/bank_slot.sv
hdl/bank_sequencer.sv
hdl/game_sdram.sv
verification/sdram_checker.sv
verification/tb_game_sdram.sv

// File: Bender.yml
package:
  name: game_sdram

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/game_sdram_pkg.sv
      - hdl/client_mapper.sv
      - hdl/bank_slot.sv
      - hdl/bank_sequencer.sv
      - hdl/game_sdram.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/sdram_checker.sv
      - verification/tb_game_sdram.sv
